// ==== include/fuse_config.svh ====
// Array geometry is fixed at 4 partitions x 16 words; digest and marker offsets must stay below 16
`ifndef FUSE_CONFIG_SVH
`define FUSE_CONFIG_SVH

// Word address and fuse word widths
`define FUSE_ADDR_W 6
`define FUSE_DATA_W 32

// Partition geometry, the partition index is the top bits of the address
`define FUSE_NUM_PART 4
`define FUSE_PART_W 2
`define FUSE_PART_WORDS 16

// Word offsets inside every partition
`define FUSE_DIGEST_OFS 14
`define FUSE_MARKER_OFS 15

// Requester IDs, only this one may touch secret partitions
`define FUSE_USER_W 8
`define FUSE_PRIV_USER 8'hA5

`endif

// ==== verilog/fuse_map_pkg.sv ====
// Partition attributes are fixed constants; changing the partition count needs new mask values
`include "fuse_config.svh"

package fuse_map_pkg;

  ////////////////////////////////////////////////////////////
  // Basic vector types
  ////////////////////////////////////////////////////////////

  // Word address into the whole array
  typedef logic [`FUSE_ADDR_W-1:0] fuse_addr_t;

  // One fuse word
  typedef logic [`FUSE_DATA_W-1:0] fuse_data_t;

  // Partition number, taken from the upper address bits
  typedef logic [`FUSE_PART_W-1:0] part_idx_t;

  // Requester ID that comes with every command
  typedef logic [`FUSE_USER_W-1:0] user_id_t;

  // Bit i describes partition i
  typedef logic [`FUSE_NUM_PART-1:0] part_mask_t;

  ////////////////////////////////////////////////////////////
  // Partition attribute table
  ////////////////////////////////////////////////////////////

  // Partitions 0 and 1 hold secrets and need the privileged user
  localparam part_mask_t PART_SECRET = 4'b0011;

  // Partitions 0 and 2 carry a zeroization marker and accept zeroize
  localparam part_mask_t PART_ZEROIZABLE = 4'b0101;

  // So the table reads as:
  //   part 0  secret, zeroizable
  //   part 1  secret
  //   part 2  public, zeroizable
  //   part 3  public

endpackage

// ==== verilog/dai_types_pkg.sv ====
// Encodings are local to this design and are not compatible with other fuse controller builds
package dai_types_pkg;

  // Commands accepted on the direct access interface
  typedef enum logic [1:0] {
    DaiRead    = 2'd0,
    DaiWrite   = 2'd1,
    DaiZeroize = 2'd2
  } dai_cmd_e;

  // Response codes returned with every done pulse
  typedef enum logic [1:0] {
    NoError       = 2'd0,
    AccessError   = 2'd1,
    FsmStateError = 2'd2
  } dai_err_e;

  // Controller state, ErrorSt is terminal until reset
  typedef enum logic {
    ActiveSt = 1'b0,
    ErrorSt  = 1'b1
  } dai_state_e;

endpackage

// ==== verilog/dai_decode.sv ====
// Accepts one request per cycle with no back-pressure; addresses outside the map cannot occur
`timescale 1ns/10ps
`include "fuse_config.svh"

module dai_decode
  import fuse_map_pkg::*;
  import dai_types_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       req_i,
  input  dai_cmd_e   cmd_i,
  input  fuse_addr_t addr_i,
  input  fuse_data_t wdata_i,
  input  user_id_t   user_i,
  output logic       valid_o,
  output dai_cmd_e   cmd_o,
  output fuse_addr_t addr_o,
  output fuse_data_t wdata_o,
  output user_id_t   user_o,
  output part_idx_t  part_o,
  output logic       below_digest_o,
  output logic       is_digest_o,
  output logic       is_marker_o
);

  localparam int unsigned OfsW = $clog2(`FUSE_PART_WORDS);
  localparam logic [OfsW-1:0] DigestOfs = OfsW'(`FUSE_DIGEST_OFS);
  localparam logic [OfsW-1:0] MarkerOfs = OfsW'(`FUSE_MARKER_OFS);

  logic [OfsW-1:0] ofs;

  // Word offset within the partition
  assign ofs = addr_i[OfsW-1:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= req_i;
    end
  end

  // Payload and address class ride along without reset
  always_ff @(posedge clk_i) begin
    cmd_o          <= cmd_i;
    addr_o         <= addr_i;
    wdata_o        <= wdata_i;
    user_o         <= user_i;
    part_o         <= addr_i[`FUSE_ADDR_W-1 -: `FUSE_PART_W];
    below_digest_o <= (ofs < DigestOfs);
    is_digest_o    <= (ofs == DigestOfs);
    is_marker_o    <= (ofs == MarkerOfs);
  end

  // A request can only enter the pipe once reset has been released
  no_valid_after_reset_a: assert property (@(posedge clk_i) $past(reset_i) |-> !valid_o);

endmodule

// ==== verilog/dai_access_check.sv ====
// Digest locks live in flops and are lost on reset; escalation is terminal until reset_i
`timescale 1ns/10ps
`include "fuse_config.svh"

module dai_access_check
  import fuse_map_pkg::*;
  import dai_types_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       escalate_i,
  input  logic       valid_i,
  input  dai_cmd_e   cmd_i,
  input  fuse_addr_t addr_i,
  input  fuse_data_t wdata_i,
  input  user_id_t   user_i,
  input  part_idx_t  part_i,
  input  logic       below_digest_i,
  input  logic       is_digest_i,
  input  logic       is_marker_i,
  output logic       valid_o,
  output dai_cmd_e   cmd_o,
  output fuse_addr_t addr_o,
  output fuse_data_t wdata_o,
  output logic       grant_o,
  output dai_err_e   err_o
);

  localparam user_id_t PrivUser = `FUSE_PRIV_USER;

  dai_state_e state_q, state_d;
  part_mask_t lock_q, lock_d;
  logic       grant_d;
  dai_err_e   err_d;
  logic       part_sec, part_zer, part_lck;

  assign part_sec = PART_SECRET[part_i];
  assign part_zer = PART_ZEROIZABLE[part_i];
  assign part_lck = lock_q[part_i];

  ////////////////////////////////////////////////////////////
  // Escalation FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ActiveSt: begin
        if (escalate_i) begin
          state_d = ErrorSt;
        end
      end
      default: state_d = ErrorSt;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Access rules, first match wins
  ////////////////////////////////////////////////////////////

  always_comb begin
    grant_d = 1'b0;
    err_d   = AccessError;
    if (state_q == ErrorSt) begin
      err_d = FsmStateError;
    end else if (cmd_i == DaiZeroize && !part_zer) begin
      err_d = AccessError;
    end else if (part_sec && user_i != PrivUser) begin
      err_d = AccessError;
    end else if (cmd_i == DaiRead && is_marker_i && part_zer) begin
      // The marker stays readable even in a locked secret partition
      grant_d = 1'b1;
      err_d   = NoError;
    end else if (cmd_i == DaiWrite && is_marker_i && part_zer) begin
      err_d = AccessError;
    end else if (cmd_i == DaiWrite && part_lck && (below_digest_i || is_digest_i)) begin
      err_d = AccessError;
    end else if (cmd_i == DaiRead && part_lck && part_sec && below_digest_i) begin
      err_d = AccessError;
    end else begin
      grant_d = 1'b1;
      err_d   = NoError;
    end
  end

  // A granted nonzero digest write locks its partition for the next command
  always_comb begin
    lock_d = lock_q;
    if (valid_i && grant_d && cmd_i == DaiWrite && is_digest_i && wdata_i != '0) begin
      lock_d[part_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ActiveSt;
      lock_q  <= '0;
      valid_o <= 1'b0;
    end else begin
      state_q <= state_d;
      lock_q  <= lock_d;
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    cmd_o   <= cmd_i;
    addr_o  <= addr_i;
    wdata_o <= wdata_i;
    grant_o <= grant_d;
    err_o   <= err_d;
  end

  // Nothing but reset may leave the terminal state
  error_state_sticky_a: assert property (@(posedge clk_i)
    (state_q == ErrorSt) && !reset_i |=> (state_q == ErrorSt));

endmodule

// ==== verilog/fuse_array.sv ====
// Fuse words are flops cleared by reset, so contents do not survive a reset like real fuses
`timescale 1ns/10ps

module fuse_array
  import fuse_map_pkg::*;
  import dai_types_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       valid_i,
  input  dai_cmd_e   cmd_i,
  input  fuse_addr_t addr_i,
  input  fuse_data_t wdata_i,
  input  logic       grant_i,
  input  dai_err_e   err_i,
  output logic       valid_o,
  output fuse_data_t rdata_o,
  output dai_err_e   err_o
);

  localparam int unsigned NumWords = 2 ** $bits(fuse_addr_t);

  fuse_data_t mem_q [NumWords];
  fuse_data_t rdata_d;
  logic       access;

  // Only granted commands may look at or change the storage
  assign access = valid_i && grant_i;

  // Zeroize answers with all ones and never exposes the old word
  always_comb begin
    rdata_d = '0;
    if (access && cmd_i == DaiRead) begin
      rdata_d = mem_q[addr_i];
    end else if (access && cmd_i == DaiZeroize) begin
      rdata_d = '1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
      mem_q   <= '{default: '0};
    end else begin
      valid_o <= valid_i;
      if (access) begin
        case (cmd_i)
          // Programming can only blow more fuses, never clear one
          DaiWrite:   mem_q[addr_i] <= mem_q[addr_i] | wdata_i;
          DaiZeroize: mem_q[addr_i] <= '1;
          default:    mem_q[addr_i] <= mem_q[addr_i];
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_o <= rdata_d;
    err_o   <= err_i;
  end

  zeroize_all_ones_a: assert property (@(posedge clk_i) disable iff (reset_i)
    access && cmd_i == DaiZeroize |=> (mem_q[$past(addr_i)] == '1) && (rdata_o == '1));

endmodule

// ==== verilog/dai_response.sv ====
// Interrupt enables are sampled with the response; a set wins over a clear in the same cycle
`timescale 1ns/10ps

module dai_response
  import fuse_map_pkg::*;
  import dai_types_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       valid_i,
  input  fuse_data_t rdata_i,
  input  dai_err_e   err_i,
  input  logic       intr_done_en_i,
  input  logic       intr_error_en_i,
  input  logic       intr_clear_i,
  output logic       done_o,
  output fuse_data_t rdata_o,
  output dai_err_e   err_o,
  output logic       intr_done_o,
  output logic       intr_error_o
);

  logic set_done, set_error;

  assign set_done  = valid_i && (err_i == NoError) && intr_done_en_i;
  assign set_error = valid_i && (err_i != NoError) && intr_error_en_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_o  <= 1'b0;
      rdata_o <= '0;
      err_o   <= NoError;
    end else begin
      done_o <= valid_i;
      // Data and code hold until the next response
      if (valid_i) begin
        rdata_o <= rdata_i;
        err_o   <= err_i;
      end
    end
  end

  // Sticky flags
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      intr_done_o  <= 1'b0;
      intr_error_o <= 1'b0;
    end else begin
      intr_done_o  <= set_done || (intr_done_o && !intr_clear_i);
      intr_error_o <= set_error || (intr_error_o && !intr_clear_i);
    end
  end

  intr_rise_with_done_a: assert property (@(posedge clk_i) disable iff (reset_i)
    ($rose(intr_done_o) || $rose(intr_error_o)) |-> done_o);

endmodule

// ==== verilog/fuse_dai_top.sv ====
// Four-stage pipe with no back-pressure; each response appears a fixed latency after its request
`timescale 1ns/10ps

module fuse_dai_top
  import fuse_map_pkg::*;
  import dai_types_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       req_i,
  input  dai_cmd_e   cmd_i,
  input  fuse_addr_t addr_i,
  input  fuse_data_t wdata_i,
  input  user_id_t   user_i,
  input  logic       escalate_i,
  input  logic       intr_done_en_i,
  input  logic       intr_error_en_i,
  input  logic       intr_clear_i,
  output logic       done_o,
  output fuse_data_t rdata_o,
  output dai_err_e   err_o,
  output logic       intr_done_o,
  output logic       intr_error_o
);

  // Decode to access check
  logic       dec_valid, dec_below_digest, dec_is_digest, dec_is_marker;
  dai_cmd_e   dec_cmd;
  fuse_addr_t dec_addr;
  fuse_data_t dec_wdata;
  user_id_t   dec_user;
  part_idx_t  dec_part;

  // Access check to array
  logic       chk_valid, chk_grant;
  dai_cmd_e   chk_cmd;
  fuse_addr_t chk_addr;
  fuse_data_t chk_wdata;
  dai_err_e   chk_err;

  // Array to response
  logic       arr_valid;
  fuse_data_t arr_rdata;
  dai_err_e   arr_err;

  dai_decode u_decode (
    .clk_i, .reset_i, .req_i, .cmd_i, .addr_i, .wdata_i, .user_i,
    .valid_o(dec_valid), .cmd_o(dec_cmd), .addr_o(dec_addr), .wdata_o(dec_wdata),
    .user_o(dec_user), .part_o(dec_part), .below_digest_o(dec_below_digest),
    .is_digest_o(dec_is_digest), .is_marker_o(dec_is_marker)
  );

  dai_access_check u_check (
    .clk_i, .reset_i, .escalate_i,
    .valid_i(dec_valid), .cmd_i(dec_cmd), .addr_i(dec_addr), .wdata_i(dec_wdata),
    .user_i(dec_user), .part_i(dec_part), .below_digest_i(dec_below_digest),
    .is_digest_i(dec_is_digest), .is_marker_i(dec_is_marker),
    .valid_o(chk_valid), .cmd_o(chk_cmd), .addr_o(chk_addr), .wdata_o(chk_wdata),
    .grant_o(chk_grant), .err_o(chk_err)
  );

  fuse_array u_array (
    .clk_i, .reset_i,
    .valid_i(chk_valid), .cmd_i(chk_cmd), .addr_i(chk_addr), .wdata_i(chk_wdata),
    .grant_i(chk_grant), .err_i(chk_err),
    .valid_o(arr_valid), .rdata_o(arr_rdata), .err_o(arr_err)
  );

  dai_response u_response (
    .clk_i, .reset_i,
    .valid_i(arr_valid), .rdata_i(arr_rdata), .err_i(arr_err),
    .intr_done_en_i, .intr_error_en_i, .intr_clear_i,
    .done_o, .rdata_o, .err_o, .intr_done_o, .intr_error_o
  );

endmodule

// ==== include/tb_fuse_model.svh ====
// Reference model for the DAI testbench; include it inside a module that imports both packages
`ifndef TB_FUSE_MODEL_SVH
`define TB_FUSE_MODEL_SVH

`include "fuse_config.svh"

////////////////////////////////////////////////////////////
// Model state
////////////////////////////////////////////////////////////

fuse_data_t model_mem [2**`FUSE_ADDR_W];
logic [`FUSE_NUM_PART-1:0] model_lock;
logic       model_escalated;

// Expected responses in request order
fuse_data_t exp_rdata_q [$];
dai_err_e   exp_err_q [$];

// Partitions 0 and 1 are secret, partitions 0 and 2 take zeroize
localparam logic [`FUSE_NUM_PART-1:0] secret_parts = 4'b0011;
localparam logic [`FUSE_NUM_PART-1:0] zero_parts   = 4'b0101;

// Everything a reset clears in the DUT
function automatic void clear_model();
  foreach (model_mem[i]) begin
    model_mem[i] = '0;
  end
  model_lock      = '0;
  model_escalated = 1'b0;
  exp_rdata_q.delete();
  exp_err_q.delete();
endfunction

function automatic void note_escalation();
  model_escalated = 1'b1;
endfunction

// Access rules in priority order, the first hit decides
function automatic dai_err_e judge_access(dai_cmd_e cmd, fuse_addr_t addr, user_id_t user);
  int part;
  int ofs;
  part = addr / `FUSE_PART_WORDS;
  ofs  = addr % `FUSE_PART_WORDS;
  if (model_escalated) return FsmStateError;
  if (cmd == DaiZeroize && !zero_parts[part]) return AccessError;
  if (secret_parts[part] && user != `FUSE_PRIV_USER) return AccessError;
  if (cmd == DaiRead && ofs == `FUSE_MARKER_OFS && zero_parts[part]) return NoError;
  if (cmd == DaiWrite && ofs == `FUSE_MARKER_OFS && zero_parts[part]) return AccessError;
  if (cmd == DaiWrite && model_lock[part] && ofs <= `FUSE_DIGEST_OFS) return AccessError;
  if (cmd == DaiRead && model_lock[part] && secret_parts[part] &&
      ofs < `FUSE_DIGEST_OFS) return AccessError;
  return NoError;
endfunction

// Applies one request to the model and queues the response the DUT must give
function automatic void predict_request(dai_cmd_e cmd, fuse_addr_t addr, fuse_data_t wdata,
                                        user_id_t user);
  dai_err_e   err;
  fuse_data_t rdata;
  err   = judge_access(cmd, addr, user);
  rdata = '0;
  if (err == NoError) begin
    case (cmd)
      DaiRead: rdata = model_mem[addr];
      DaiWrite: begin
        // Fuses only ever get blown, so a write is an OR
        model_mem[addr] = model_mem[addr] | wdata;
        if (addr % `FUSE_PART_WORDS == `FUSE_DIGEST_OFS && wdata != '0) begin
          model_lock[addr / `FUSE_PART_WORDS] = 1'b1;
        end
      end
      default: begin
        model_mem[addr] = '1;
        rdata           = '1;
      end
    endcase
  end
  exp_rdata_q.push_back(rdata);
  exp_err_q.push_back(err);
endfunction

`endif

// ==== tb/tb_fuse_dai.sv ====
// Random stimulus uses seed 23; the fuse model restarts at every reset because the array is flops
`timescale 1ns/10ps
`include "fuse_config.svh"

module tb_fuse_dai
  import fuse_map_pkg::*;
  import dai_types_pkg::*;
();

  // Requests per test, they set the cycle budget
  localparam int n_basic = 40;
  localparam int n_secret = 10;
  localparam int n_lock = 6;
  localparam int n_zero = 8;
  localparam int n_intr = 24;
  localparam int n_esc = 6;
  localparam int max_cycles = 2 * (n_basic + n_secret + n_lock + n_zero + n_intr + n_esc) + 50;
  localparam user_id_t priv_user = `FUSE_PRIV_USER;

  logic       clk_i, reset_i, req_i;
  dai_cmd_e   cmd_i;
  fuse_addr_t addr_i;
  fuse_data_t wdata_i;
  user_id_t   user_i;
  logic       escalate_i, intr_done_en_i, intr_error_en_i, intr_clear_i;
  logic       done_o, intr_done_o, intr_error_o;
  fuse_data_t rdata_o;
  dai_err_e   err_o;

  integer     seed = 23;
  int         errors = 0;
  int         test_errors = 0;
  int         cycles = 0;
  logic [3:0] req_hist = '0;
  logic       rst_prev = 1'b1;
  logic       den_prev = 1'b0;
  logic       een_prev = 1'b0;
  logic       clr_prev = 1'b0;
  logic       exp_intr_done = 1'b0;
  logic       exp_intr_error = 1'b0;

  `include "tb_fuse_model.svh"

  fuse_dai_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response monitor, samples in the middle of each cycle
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    fuse_data_t exp_rdata;
    dai_err_e   exp_err;
    exp_rdata = '0;
    exp_err   = NoError;
    // A request seen four cycles ago must be answered now
    assert (done_o === req_hist[3]) else begin
      $display("Error at %0t: done_o is %b, expected %b", $time, done_o, req_hist[3]);
      errors++;
    end
    if (done_o === 1'b1) begin
      assert (exp_err_q.size() > 0) else begin
        $display("A done pulse at %0t had no outstanding request", $time);
        errors++;
      end
      if (exp_err_q.size() > 0) begin
        exp_rdata = exp_rdata_q.pop_front();
        exp_err   = exp_err_q.pop_front();
        assert (rdata_o === exp_rdata && err_o === exp_err) else begin
          $display("Error at %0t: rdata %h err %s, expected rdata %h err %s", $time,
                   rdata_o, err_o.name(), exp_rdata, exp_err.name());
          errors++;
        end
      end
    end
    // The DUT saw enables and clear as they stood half a cycle ago
    if (rst_prev) begin
      exp_intr_done  = 1'b0;
      exp_intr_error = 1'b0;
    end else begin
      exp_intr_done  = (req_hist[3] && exp_err == NoError && den_prev) ||
                       (exp_intr_done && !clr_prev);
      exp_intr_error = (req_hist[3] && exp_err != NoError && een_prev) ||
                       (exp_intr_error && !clr_prev);
      assert (intr_done_o === exp_intr_done && intr_error_o === exp_intr_error) else begin
        $display("Error at %0t: interrupts done %b error %b, expected %b %b", $time,
                 intr_done_o, intr_error_o, exp_intr_done, exp_intr_error);
        errors++;
      end
    end
    req_hist = {req_hist[2:0], req_i};
    rst_prev = reset_i;
    den_prev = intr_done_en_i;
    een_prev = intr_error_en_i;
    clr_prev = intr_clear_i;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic int pick_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic user_id_t other_user();
    user_id_t u;
    u = user_id_t'($random(seed));
    if (u == priv_user) u = u ^ 8'h01;
    return u;
  endfunction

  function automatic fuse_addr_t word_addr(int part, int ofs);
    return fuse_addr_t'(part * `FUSE_PART_WORDS + ofs);
  endfunction

  // Called on a rising edge, returns on the next one
  task automatic issue(input dai_cmd_e cmd, input fuse_addr_t addr, input fuse_data_t wdata,
                       input user_id_t user);
    req_i   <= 1'b1;
    cmd_i   <= cmd;
    addr_i  <= addr;
    wdata_i <= wdata;
    user_i  <= user;
    predict_request(cmd, addr, wdata, user);
    @(posedge clk_i);
  endtask

  task automatic drain();
    req_i <= 1'b0;
    while (exp_err_q.size() > 0) begin
      @(posedge clk_i);
    end
    @(posedge clk_i);
  endtask

  task automatic report_test(input string name);
    if (errors == test_errors) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin
    user_id_t user;
    reset_i         = 1'b1;
    req_i           = 1'b0;
    cmd_i           = DaiRead;
    addr_i          = '0;
    wdata_i         = '0;
    user_i          = '0;
    escalate_i      = 1'b0;
    intr_done_en_i  = 1'b1;
    intr_error_en_i = 1'b1;
    intr_clear_i    = 1'b0;
    clear_model();
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;

    // Public partitions, mostly back to back with a few gaps
    for (int i = 0; i < n_basic; i++) begin
      issue(pick_below(2) == 1 ? DaiWrite : DaiRead, word_addr(2 + pick_below(2), pick_below(4)),
            $random(seed), user_id_t'($random(seed)));
      if (pick_below(4) == 0) begin
        req_i <= 1'b0;
        @(posedge clk_i);
      end
    end
    drain();
    report_test("public read/write");

    for (int i = 0; i < 4; i++) begin
      issue(dai_cmd_e'(pick_below(2)), word_addr(pick_below(2), pick_below(14)),
            $random(seed), other_user());
    end
    issue(DaiWrite, word_addr(1, 2), $random(seed), priv_user);
    issue(DaiRead, word_addr(1, 2), '0, priv_user);
    issue(DaiWrite, word_addr(1, 14), $random(seed) | 1, priv_user);
    issue(DaiRead, word_addr(1, 2), '0, priv_user);
    issue(DaiWrite, word_addr(1, 3), $random(seed), priv_user);
    issue(DaiRead, word_addr(1, 14), '0, priv_user);
    drain();
    report_test("secret partition");

    issue(DaiWrite, word_addr(3, 5), $random(seed), other_user());
    issue(DaiWrite, word_addr(3, 14), $random(seed) | 32'h100, other_user());
    issue(DaiWrite, word_addr(3, 5), $random(seed), other_user());
    issue(DaiWrite, word_addr(3, 14), $random(seed), other_user());
    issue(DaiRead, word_addr(3, 5), '0, other_user());
    issue(DaiRead, word_addr(3, 14), '0, other_user());
    drain();
    report_test("public digest lock");

    issue(DaiZeroize, word_addr(0, 4), '0, priv_user);
    issue(DaiRead, word_addr(0, 4), '0, priv_user);
    issue(DaiZeroize, word_addr(2, 7), '0, other_user());
    issue(DaiRead, word_addr(2, 7), '0, other_user());
    issue(DaiZeroize, word_addr(1, 1), '0, priv_user);
    issue(DaiZeroize, word_addr(3, 1), '0, priv_user);
    issue(DaiRead, word_addr(2, 15), '0, other_user());
    issue(DaiWrite, word_addr(2, 15), $random(seed), other_user());
    drain();
    report_test("zeroize and marker");

    // Random enables and clears over a mix of good and refused commands
    for (int i = 0; i < n_intr; i++) begin
      intr_done_en_i  <= pick_below(2) == 1;
      intr_error_en_i <= pick_below(2) == 1;
      intr_clear_i    <= pick_below(4) == 0;
      user = pick_below(2) == 1 ? priv_user : other_user();
      issue(dai_cmd_e'(pick_below(3)), word_addr(pick_below(4), pick_below(16)),
            $random(seed), user);
    end
    intr_clear_i <= 1'b0;
    drain();
    intr_clear_i <= 1'b1;
    @(posedge clk_i);
    intr_clear_i    <= 1'b0;
    intr_done_en_i  <= 1'b1;
    intr_error_en_i <= 1'b1;
    @(posedge clk_i);
    report_test("interrupts");

    escalate_i <= 1'b1;
    @(posedge clk_i);
    escalate_i <= 1'b0;
    note_escalation();
    for (int i = 0; i < 4; i++) begin
      issue(dai_cmd_e'(pick_below(3)), word_addr(pick_below(4), pick_below(16)),
            $random(seed), priv_user);
    end
    drain();
    reset_i <= 1'b1;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    clear_model();
    issue(DaiWrite, word_addr(2, 0), $random(seed), priv_user);
    issue(DaiRead, word_addr(2, 0), '0, priv_user);
    drain();
    report_test("escalation");

    $display("Summary: 6 tests, %0d errors, %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
verilog/fuse_map_pkg.sv
verilog/dai_types_pkg.sv
verilog/dai_decode.sv
verilog/dai_access_check.sv
verilog/fuse_array.sv
verilog/dai_response.sv
verilog/fuse_dai_top.sv
tb/tb_fuse_dai.sv
